// File: rtl/mem_config.svh
// Memory subsystem configuration
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// ############################################################
// data path
// ############################################################

`define MEM_XLEN 32 // data and address width.

// ############################################################
// bank depths in words
// ############################################################

`define MEM_IRAM_WORDS 1024
`define MEM_DRAM_WORDS 1024

// region tags, matched against address bits 31 to 16.
`define MEM_IRAM_TAG 16'h0000
`define MEM_DRAM_TAG 16'h1000

`endif

// File: rtl/mem_map_pkg.sv
// Memory map types
`default_nettype none

`include "mem_config.svh"

package mem_map_pkg;

typedef enum logic [1:0] {
    REGION_IRAM = 2'b00,
    REGION_DRAM = 2'b01,
    REGION_NONE = 2'b11
} region_e;

typedef logic [1:0] lane_t; // byte offset within a word.

function automatic region_e decode_region(input logic [`MEM_XLEN-1:0] addr);
    return (addr[`MEM_XLEN-1:16] == `MEM_IRAM_TAG) ? REGION_IRAM :
           (addr[`MEM_XLEN-1:16] == `MEM_DRAM_TAG) ? REGION_DRAM : REGION_NONE;
endfunction

endpackage

`default_nettype wire

// File: rtl/loader_pkg.sv
// Host loader types
`default_nettype none

package loader_pkg;

typedef enum logic {
    LOAD_OP_WRITE = 1'b0,
    LOAD_OP_READ  = 1'b1
} load_op_e;

typedef enum logic [1:0] {
    IDLE      = 2'b00,
    ACCESS    = 2'b01,
    WAIT_DATA = 2'b10,
    ACK_HOLD  = 2'b11
} load_state_e;

endpackage

`default_nettype wire

// File: rtl/bank_port_if.sv
// Byte bank port bundle
`timescale 1ns/100ps
`default_nettype none

interface bank_port_if #(
    parameter int AW = 10
);

logic               rd_en;
logic [3:0][AW-1:0] rd_addr; // per-lane word address.
logic [3:0][7:0]    rd_data;

logic               wr_en;
logic [3:0][AW-1:0] wr_addr;
logic [3:0][7:0]    wr_data;
logic [3:0]         wr_strb;

modport router (
    output rd_en,
    output rd_addr,
    input  rd_data,
    output wr_en,
    output wr_addr,
    output wr_data,
    output wr_strb
);

modport bank (
    input  rd_en,
    input  rd_addr,
    output rd_data,
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  wr_strb
);

endinterface

`default_nettype wire

// File: rtl/byte_bank.sv
// Four-lane byte memory
`timescale 1ns/100ps
`default_nettype none

module byte_bank #(
    parameter int DEPTH = 1024
) (
    input logic clk_i,

    bank_port_if.bank bp
);

// ############################################################
// byte lanes
// ############################################################

for (genvar i = 0; i < 4; i++) begin : g_lane
    logic [7:0] mem [DEPTH];
    logic [7:0] rd_q;

    always_ff @(posedge clk_i) begin
        if (bp.wr_en && bp.wr_strb[i]) begin
            mem[bp.wr_addr[i]] <= bp.wr_data[i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (bp.rd_en) begin
            rd_q <= mem[bp.rd_addr[i]]; // old byte on a same-cycle write.
        end
    end

    assign bp.rd_data[i] = rd_q;
end

// ############################################################
// checks
// ############################################################

// router must hand over clean lane addresses whenever a port is live.
a_rd_addr_known: assert property (
    @(posedge clk_i) bp.rd_en |-> !$isunknown(bp.rd_addr)
) else $error("byte_bank: read lane address unknown");

a_wr_addr_known: assert property (
    @(posedge clk_i) (bp.wr_en && (|bp.wr_strb)) |-> !$isunknown(bp.wr_addr)
) else $error("byte_bank: write lane address unknown");

endmodule

`default_nettype wire

// File: rtl/lane_router.sv
// Unaligned word access router
`timescale 1ns/100ps
`default_nettype none

`include "mem_config.svh"

module lane_router #(
    parameter int DEPTH = 1024
) (
    input logic clk_i,
    input logic rst_n_i,

    input logic                 rd_en_i,
    input logic [`MEM_XLEN-1:0] rd_addr_i,

    input logic                 wr_en_i,
    input logic [`MEM_XLEN-1:0] wr_addr_i,
    input logic [`MEM_XLEN-1:0] wr_data_i,
    input logic           [3:0] wr_byte_en_i,

    output logic [`MEM_XLEN-1:0] rd_data_o,

    bank_port_if.router bp
);

localparam int AW = $clog2(DEPTH);

mem_map_pkg::lane_t rd_off;
mem_map_pkg::lane_t wr_off;
mem_map_pkg::lane_t rd_off_q;

logic [AW-1:0] rd_word;
logic [AW-1:0] rd_word_nx;
logic [AW-1:0] wr_word;
logic [AW-1:0] wr_word_nx;

// upper address bits fall away, so the next word wraps at the depth.
assign rd_off     = rd_addr_i[1:0];
assign rd_word    = rd_addr_i[AW+1:2];
assign rd_word_nx = rd_word + 1'b1;

assign wr_off     = wr_addr_i[1:0];
assign wr_word    = wr_addr_i[AW+1:2];
assign wr_word_nx = wr_word + 1'b1;

assign bp.rd_en = rd_en_i;
assign bp.wr_en = wr_en_i;

// ############################################################
// lane split
// ############################################################

always_comb begin
    for (int i = 0; i < 4; i++) begin
        // lanes below the offset belong to the next word.
        bp.rd_addr[i] = (mem_map_pkg::lane_t'(i) < rd_off) ? rd_word_nx : rd_word;
    end
end

always_comb begin
    mem_map_pkg::lane_t wr_src;

    for (int i = 0; i < 4; i++) begin
        wr_src        = mem_map_pkg::lane_t'(i) - wr_off; // rotate left by offset.
        bp.wr_addr[i] = (mem_map_pkg::lane_t'(i) < wr_off) ? wr_word_nx : wr_word;
        bp.wr_data[i] = wr_data_i[8*wr_src +: 8];
        bp.wr_strb[i] = wr_byte_en_i[wr_src];
    end
end

// ############################################################
// read realign
// ############################################################

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        rd_off_q <= 2'b00;
    end else if (rd_en_i) begin
        rd_off_q <= rd_off; // tracks the bank read in flight.
    end
end

always_comb begin
    mem_map_pkg::lane_t rd_src;

    for (int j = 0; j < 4; j++) begin
        rd_src              = mem_map_pkg::lane_t'(j) + rd_off_q;
        rd_data_o[8*j +: 8] = bp.rd_data[rd_src]; // addressed byte lands in byte 0.
    end
end

a_off_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rd_en_i |=> !$isunknown(rd_off_q)
) else $error("lane_router: registered read offset unknown");

endmodule

`default_nettype wire

// File: rtl/split_ram.sv
// IRAM and DRAM with loader access
`timescale 1ns/100ps
`default_nettype none

`include "mem_config.svh"

module split_ram (
    input logic clk_i,
    input logic rst_n_i,

    input logic                 ldr_sel_i,
    input logic [`MEM_XLEN-1:0] ldr_addr_i,
    input logic           [7:0] ldr_wdata_i,
    input logic           [3:0] ldr_byte_en_i,

    input logic [`MEM_XLEN-1:0] iram_rd_addr_i,

    input logic [`MEM_XLEN-1:0] dram_rd_addr_i,
    input logic [`MEM_XLEN-1:0] dram_wr_addr_i,
    input logic [`MEM_XLEN-1:0] dram_wr_data_i,
    input logic           [3:0] dram_wr_byte_en_i,

    output logic [`MEM_XLEN-1:0] iram_rd_data_o,
    output logic [`MEM_XLEN-1:0] dram_rd_data_o,
    output logic           [7:0] ldr_rdata_o
);

localparam int IRAM_AW = $clog2(`MEM_IRAM_WORDS);
localparam int DRAM_AW = $clog2(`MEM_DRAM_WORDS);

logic [`MEM_XLEN-1:0] iram_addr;
logic [`MEM_XLEN-1:0] dram_rd_addr;
logic [`MEM_XLEN-1:0] dram_wr_addr;
logic [`MEM_XLEN-1:0] dram_wr_data;
logic           [3:0] dram_wr_byte_en;
logic [`MEM_XLEN-1:0] ldr_wdata_x4;

logic iram_rd_en;
logic iram_wr_en;
logic dram_rd_en;
logic dram_wr_en;

mem_map_pkg::region_e ldr_region_q;

bank_port_if #(.AW(IRAM_AW)) iram_bp ();
bank_port_if #(.AW(DRAM_AW)) dram_bp ();

assign ldr_wdata_x4 = {4{ldr_wdata_i}}; // the strobe picks the lane.

// ############################################################
// source select and region decode
// ############################################################

always_comb begin
    if (ldr_sel_i) begin
        iram_addr       = ldr_addr_i;
        dram_rd_addr    = ldr_addr_i;
        dram_wr_addr    = ldr_addr_i;
        dram_wr_data    = ldr_wdata_x4;
        dram_wr_byte_en = ldr_byte_en_i;
    end else begin
        iram_addr       = iram_rd_addr_i;
        dram_rd_addr    = dram_rd_addr_i;
        dram_wr_addr    = dram_wr_addr_i;
        dram_wr_data    = dram_wr_data_i;
        dram_wr_byte_en = dram_wr_byte_en_i;
    end
end

assign iram_rd_en = (mem_map_pkg::decode_region(iram_addr) == mem_map_pkg::REGION_IRAM);
assign iram_wr_en = ldr_sel_i && iram_rd_en; // no core write path into IRAM.
assign dram_rd_en = (mem_map_pkg::decode_region(dram_rd_addr) == mem_map_pkg::REGION_DRAM);
assign dram_wr_en = (mem_map_pkg::decode_region(dram_wr_addr) == mem_map_pkg::REGION_DRAM);

// ############################################################
// routers and banks
// ############################################################

lane_router #(.DEPTH(`MEM_IRAM_WORDS)) u_iram_router (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rd_en_i      (iram_rd_en),
    .rd_addr_i    (iram_addr),
    .wr_en_i      (iram_wr_en),
    .wr_addr_i    (iram_addr),
    .wr_data_i    (ldr_wdata_x4),
    .wr_byte_en_i (ldr_byte_en_i),
    .rd_data_o    (iram_rd_data_o),
    .bp           (iram_bp.router)
);

byte_bank #(.DEPTH(`MEM_IRAM_WORDS)) u_iram_bank (
    .clk_i (clk_i),
    .bp    (iram_bp.bank)
);

lane_router #(.DEPTH(`MEM_DRAM_WORDS)) u_dram_router (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rd_en_i      (dram_rd_en),
    .rd_addr_i    (dram_rd_addr),
    .wr_en_i      (dram_wr_en),
    .wr_addr_i    (dram_wr_addr),
    .wr_data_i    (dram_wr_data),
    .wr_byte_en_i (dram_wr_byte_en),
    .rd_data_o    (dram_rd_data_o),
    .bp           (dram_bp.router)
);

byte_bank #(.DEPTH(`MEM_DRAM_WORDS)) u_dram_bank (
    .clk_i (clk_i),
    .bp    (dram_bp.bank)
);

// ############################################################
// loader read byte
// ############################################################

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        ldr_region_q <= mem_map_pkg::REGION_NONE;
    end else begin
        ldr_region_q <= mem_map_pkg::decode_region(ldr_addr_i);
    end
end

always_comb begin
    case (ldr_region_q)
        mem_map_pkg::REGION_IRAM: ldr_rdata_o = iram_rd_data_o[7:0];
        mem_map_pkg::REGION_DRAM: ldr_rdata_o = dram_rd_data_o[7:0];
        default:                  ldr_rdata_o = 8'h00; // unmapped reads as zero.
    endcase
end

// byte replication only works with a single lane strobed per loader write.
a_ldr_single_byte: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) ldr_sel_i |-> $onehot0(ldr_byte_en_i)
) else $error("split_ram: loader strobes more than one byte");

endmodule

`default_nettype wire

// File: rtl/boot_loader.sv
// Host loader port
`timescale 1ns/100ps
`default_nettype none

`include "mem_config.svh"

module boot_loader (
    input logic clk_i,
    input logic rst_n_i,

    input  logic                 host_req_i,
    input  loader_pkg::load_op_e host_op_i,
    input  logic [`MEM_XLEN-1:0] host_addr_i,
    input  logic           [7:0] host_wdata_i,
    output logic                 host_ack_o,
    output logic           [7:0] host_rdata_o,

    output logic                 ldr_sel_o,
    output logic [`MEM_XLEN-1:0] ldr_addr_o,
    output logic           [7:0] ldr_wdata_o,
    output logic           [3:0] ldr_byte_en_o,
    input  logic           [7:0] ldr_rdata_i
);

loader_pkg::load_state_e state_q;
loader_pkg::load_state_e state_d;
loader_pkg::load_op_e    op_q;

logic [`MEM_XLEN-1:0] addr_q;
logic           [7:0] wdata_q;
logic           [7:0] rdata_q;
logic                 ack_q;

// ############################################################
// FSM
// ############################################################

always_comb begin
    state_d = state_q;

    case (state_q)
        loader_pkg::IDLE: begin
            if (host_req_i && !ack_q) begin
                state_d = loader_pkg::ACCESS;
            end
        end
        loader_pkg::ACCESS: begin
            state_d = (op_q == loader_pkg::LOAD_OP_READ) ? loader_pkg::WAIT_DATA
                                                         : loader_pkg::ACK_HOLD;
        end
        loader_pkg::WAIT_DATA: state_d = loader_pkg::ACK_HOLD;
        loader_pkg::ACK_HOLD: begin
            if (!host_req_i && ack_q) begin
                state_d = loader_pkg::IDLE;
            end
        end
        default: state_d = loader_pkg::IDLE;
    endcase
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state_q <= loader_pkg::IDLE;
        ack_q   <= 1'b0;
    end else begin
        state_q <= state_d;
        ack_q   <= (state_q == loader_pkg::ACK_HOLD); // one edge behind the state.
    end
end

always_ff @(posedge clk_i) begin
    if (state_q == loader_pkg::IDLE && state_d == loader_pkg::ACCESS) begin
        op_q    <= host_op_i;
        addr_q  <= host_addr_i;
        wdata_q <= host_wdata_i;
    end

    if (state_q == loader_pkg::WAIT_DATA) begin
        rdata_q <= ldr_rdata_i;
    end
end

// RAM stays with the loader until ack has dropped.
assign ldr_sel_o     = (state_q != loader_pkg::IDLE) || ack_q;
assign ldr_addr_o    = addr_q;
assign ldr_wdata_o   = wdata_q;
assign ldr_byte_en_o = (state_q == loader_pkg::ACCESS && op_q == loader_pkg::LOAD_OP_WRITE)
                       ? 4'b0001 : 4'b0000;

assign host_ack_o   = ack_q;
assign host_rdata_o = rdata_q;

a_req_held: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $fell(host_req_i) |-> $past(host_ack_o)
) else $error("boot_loader: host dropped req before ack");

a_ack_under_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $rose(host_ack_o) |-> host_req_i
) else $error("boot_loader: ack raised without a pending req");

endmodule

`default_nettype wire

// File: rtl/mem_subsys_top.sv
// Memory subsystem top
`timescale 1ns/100ps
`default_nettype none

`include "mem_config.svh"

module mem_subsys_top (
    input logic clk_i,
    input logic rst_n_i,

    // host loader.
    input  logic                 host_req_i,
    input  loader_pkg::load_op_e host_op_i,
    input  logic [`MEM_XLEN-1:0] host_addr_i,
    input  logic           [7:0] host_wdata_i,
    output logic                 host_ack_o,
    output logic           [7:0] host_rdata_o,

    // core side.
    input  logic [`MEM_XLEN-1:0] iram_rd_addr_i,
    input  logic [`MEM_XLEN-1:0] dram_rd_addr_i,
    input  logic [`MEM_XLEN-1:0] dram_wr_addr_i,
    input  logic [`MEM_XLEN-1:0] dram_wr_data_i,
    input  logic           [3:0] dram_wr_byte_en_i,
    output logic [`MEM_XLEN-1:0] iram_rd_data_o,
    output logic [`MEM_XLEN-1:0] dram_rd_data_o
);

logic                 ldr_sel;
logic [`MEM_XLEN-1:0] ldr_addr;
logic           [7:0] ldr_wdata;
logic           [3:0] ldr_byte_en;
logic           [7:0] ldr_rdata;

boot_loader u_boot_loader (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .host_req_i    (host_req_i),
    .host_op_i     (host_op_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .host_ack_o    (host_ack_o),
    .host_rdata_o  (host_rdata_o),
    .ldr_sel_o     (ldr_sel),
    .ldr_addr_o    (ldr_addr),
    .ldr_wdata_o   (ldr_wdata),
    .ldr_byte_en_o (ldr_byte_en),
    .ldr_rdata_i   (ldr_rdata)
);

split_ram u_split_ram (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .ldr_sel_i         (ldr_sel),
    .ldr_addr_i        (ldr_addr),
    .ldr_wdata_i       (ldr_wdata),
    .ldr_byte_en_i     (ldr_byte_en),
    .iram_rd_addr_i    (iram_rd_addr_i),
    .dram_rd_addr_i    (dram_rd_addr_i),
    .dram_wr_addr_i    (dram_wr_addr_i),
    .dram_wr_data_i    (dram_wr_data_i),
    .dram_wr_byte_en_i (dram_wr_byte_en_i),
    .iram_rd_data_o    (iram_rd_data_o),
    .dram_rd_data_o    (dram_rd_data_o),
    .ldr_rdata_o       (ldr_rdata)
);

endmodule

`default_nettype wire

// File: tb/mem_checker.sv
// Memory response checker
`timescale 1ns/100ps
`default_nettype none

module mem_checker (
    input logic clk_i,
    input logic rst_n_i,

    input logic                 host_req_i,
    input loader_pkg::load_op_e host_op_i,
    input logic           [7:0] host_exp_i,
    input logic                 host_ack_i,
    input logic           [7:0] host_rdata_i,

    input logic        iram_chk_i,
    input logic [31:0] iram_exp_i,
    input logic [31:0] iram_rd_data_i,
    input logic        dram_chk_i,
    input logic [31:0] dram_exp_i,
    input logic [31:0] dram_rd_data_i,

    output int chk_cnt_o,
    output int err_cnt_o
);

logic                 req_q = 1'b0;
loader_pkg::load_op_e op_q;
logic           [7:0] host_exp_q;
logic                 iram_chk_q = 1'b0;
logic          [31:0] iram_exp_q;
logic                 dram_chk_q = 1'b0;
logic          [31:0] dram_exp_q;

logic busy = 1'b0;
logic ack_seen = 1'b0;
int   edges = 0;
int   exp_edges;
int   chks = 0;
int   errs = 0;

assign chk_cnt_o = chks;
assign err_cnt_o = errs;

task automatic compare_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    chks++;
    if (got !== exp) begin
        errs++;
        $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
    end
endtask

// ############################################################
// sample requests at the edge and responses mid-cycle
// ############################################################

always @(posedge clk_i) begin
    req_q      <= host_req_i;
    op_q       <= host_op_i;
    host_exp_q <= host_exp_i;
    iram_chk_q <= iram_chk_i;
    iram_exp_q <= iram_exp_i;
    dram_chk_q <= dram_chk_i;
    dram_exp_q <= dram_exp_i;
end

always @(negedge clk_i) begin
    if (!rst_n_i) begin
        busy = 1'b0;
        ack_seen = 1'b0;
        edges = 0;
    end else begin
        if (iram_chk_q) compare_word("iram_rd_data_o", iram_rd_data_i, iram_exp_q);
        if (dram_chk_q) compare_word("dram_rd_data_o", dram_rd_data_i, dram_exp_q);

        if (!busy) begin
            if (req_q) begin
                busy = 1'b1; // req seen at the last edge.
                edges = 1;
            end
        end else if (!ack_seen) begin
            edges++;
            if (host_ack_i) begin
                ack_seen = 1'b1;
                // seen edge plus two for writes or three for reads.
                exp_edges = (op_q == loader_pkg::LOAD_OP_READ) ? 4 : 3;
                chks++;
                if (edges != exp_edges) begin
                    errs++;
                    $display("Fail t=%0t host_ack_o rise edge got %0d expected %0d",
                             $time, edges, exp_edges);
                end
                if (op_q == loader_pkg::LOAD_OP_READ) begin
                    compare_word("host_rdata_o", {24'h0, host_rdata_i}, {24'h0, host_exp_q});
                end
            end
        end else if (!host_ack_i) begin
            busy = 1'b0;
            ack_seen = 1'b0;
        end
    end
end

endmodule

`default_nettype wire

// File: tb/tb_mem_subsys.sv
// Memory subsystem testbench
`timescale 1ns/100ps
`default_nettype none

`include "mem_config.svh"

module tb_mem_subsys;

localparam int CLK_HALF    = 50;
localparam int RST_CYCLES  = 8;
localparam int IRAM_BYTES  = 4 * `MEM_IRAM_WORDS;
localparam int DRAM_BYTES  = 4 * `MEM_DRAM_WORDS;
localparam int WIN_BASE    = 'hff0; // window wraps over the bank top.
localparam int WIN_BYTES   = 64;
localparam int WIN_SPAN    = WIN_BYTES - 3; // word starts inside the window.
localparam int DWR_COUNT   = 40;
localparam int DRD_COUNT   = 100;
localparam int OOR_COUNT   = 8;
localparam int NOISE_COUNT = 8;
localparam int HS_LIMIT    = 20;
localparam int NUM_OPS     = 4 * WIN_BYTES + 4 * WIN_SPAN + DWR_COUNT + DRD_COUNT
                             + 4 * OOR_COUNT + NOISE_COUNT;
localparam int WATCHDOG_NS = (10 * NUM_OPS + RST_CYCLES + 100) * 2 * CLK_HALF;

logic                 clk = 1'b0;
logic                 rst_n;
logic                 host_req;
loader_pkg::load_op_e host_op;
logic [`MEM_XLEN-1:0] host_addr;
logic           [7:0] host_wdata;
logic                 host_ack;
logic           [7:0] host_rdata;
logic           [7:0] host_exp;
logic [`MEM_XLEN-1:0] iram_rd_addr;
logic [`MEM_XLEN-1:0] dram_rd_addr;
logic [`MEM_XLEN-1:0] dram_wr_addr;
logic [`MEM_XLEN-1:0] dram_wr_data;
logic           [3:0] dram_wr_byte_en;
logic [`MEM_XLEN-1:0] iram_rd_data;
logic [`MEM_XLEN-1:0] dram_rd_data;
logic [`MEM_XLEN-1:0] iram_exp;
logic [`MEM_XLEN-1:0] dram_exp;
logic                 iram_chk;
logic                 dram_chk;

logic [7:0] iram_model [IRAM_BYTES];
logic [7:0] dram_model [DRAM_BYTES];
logic [31:0] rng;
int hs_errs = 0;
int chk_cnt;
int err_cnt;

always #CLK_HALF clk = ~clk;

mem_subsys_top dut0 (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .host_req_i        (host_req),
    .host_op_i         (host_op),
    .host_addr_i       (host_addr),
    .host_wdata_i      (host_wdata),
    .host_ack_o        (host_ack),
    .host_rdata_o      (host_rdata),
    .iram_rd_addr_i    (iram_rd_addr),
    .dram_rd_addr_i    (dram_rd_addr),
    .dram_wr_addr_i    (dram_wr_addr),
    .dram_wr_data_i    (dram_wr_data),
    .dram_wr_byte_en_i (dram_wr_byte_en),
    .iram_rd_data_o    (iram_rd_data),
    .dram_rd_data_o    (dram_rd_data)
);

mem_checker u_checker (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .host_req_i     (host_req),
    .host_op_i      (host_op),
    .host_exp_i     (host_exp),
    .host_ack_i     (host_ack),
    .host_rdata_i   (host_rdata),
    .iram_chk_i     (iram_chk),
    .iram_exp_i     (iram_exp),
    .iram_rd_data_i (iram_rd_data),
    .dram_chk_i     (dram_chk),
    .dram_exp_i     (dram_exp),
    .dram_rd_data_i (dram_rd_data),
    .chk_cnt_o      (chk_cnt),
    .err_cnt_o      (err_cnt)
);

// ############################################################
// reference model
// ############################################################

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// little-endian word from the byte at addr upward, zero when unmapped.
function automatic logic [31:0] ref_word(input logic [31:0] addr);
    logic [31:0] w;
    w = '0;
    for (int k = 0; k < 4; k++) begin
        if (addr[31:16] == `MEM_IRAM_TAG) begin
            w[8*k +: 8] = iram_model[int'((addr + k) % IRAM_BYTES)];
        end else if (addr[31:16] == `MEM_DRAM_TAG) begin
            w[8*k +: 8] = dram_model[int'((addr + k) % DRAM_BYTES)];
        end
    end
    return w;
endfunction

function automatic logic [31:0] win_addr(input logic [15:0] tag, input int r, input int bytes);
    logic [15:0] low;
    low = 16'((WIN_BASE + r) % bytes);
    return {tag, low};
endfunction

function automatic logic [15:0] oor_tag(input int i);
    case (i % 4)
        0:       return 16'h2000;
        1:       return 16'h1001;
        2:       return 16'hffff;
        default: return 16'h0001;
    endcase
endfunction

// core writes never reach IRAM.
task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] be, input bit from_core);
    for (int k = 0; k < 4; k++) begin
        if (be[k] && addr[31:16] == `MEM_DRAM_TAG) begin
            dram_model[int'((addr + k) % DRAM_BYTES)] = data[8*k +: 8];
        end else if (be[k] && !from_core && addr[31:16] == `MEM_IRAM_TAG) begin
            iram_model[int'((addr + k) % IRAM_BYTES)] = data[8*k +: 8];
        end
    end
endtask

// ############################################################
// stimulus tasks
// ############################################################

task automatic drive_noise();
    rng = xorshift(rng);
    dram_wr_addr = win_addr(`MEM_DRAM_TAG, int'(rng % WIN_SPAN), DRAM_BYTES);
    rng = xorshift(rng);
    dram_wr_data = rng;
    dram_wr_byte_en = 4'hf;
endtask

task automatic host_access(input loader_pkg::load_op_e op, input logic [31:0] addr,
                           input logic [7:0] wdata, input bit noise);
    logic [31:0] w;
    int n;
    @(negedge clk);
    w = ref_word(addr);
    host_exp = w[7:0];
    if (op == loader_pkg::LOAD_OP_WRITE) begin
        model_write(addr, {24'h0, wdata}, 4'b0001, 1'b0);
    end
    host_op = op;
    host_addr = addr;
    host_wdata = wdata;
    host_req = 1'b1;
    n = 0;
    do begin
        @(negedge clk);
        n++;
        if (noise) drive_noise();
    end while (!host_ack && n < HS_LIMIT);
    if (!host_ack) begin
        $display("loader never raised ack for the access at %h", addr);
        hs_errs++;
    end
    @(negedge clk); // req stays up one more edge after ack.
    if (noise) drive_noise();
    host_req = 1'b0;
    n = 0;
    while (host_ack && n < HS_LIMIT) begin
        @(negedge clk);
        n++;
        if (noise && host_ack) drive_noise();
    end
    if (host_ack) begin
        $display("loader kept ack high after req dropped, address %h", addr);
        hs_errs++;
    end
    dram_wr_byte_en = 4'h0;
endtask

task automatic core_write(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] be);
    @(negedge clk);
    dram_wr_addr = addr;
    dram_wr_data = data;
    dram_wr_byte_en = be;
    model_write(addr, data, be, 1'b1);
endtask

task automatic core_idle();
    @(negedge clk);
    dram_wr_byte_en = 4'h0;
endtask

task automatic verify_window();
    for (int r = 0; r < WIN_SPAN; r++) begin
        @(negedge clk);
        iram_rd_addr = win_addr(`MEM_IRAM_TAG, r, IRAM_BYTES);
        dram_rd_addr = win_addr(`MEM_DRAM_TAG, r, DRAM_BYTES);
        iram_exp = ref_word(iram_rd_addr);
        dram_exp = ref_word(dram_rd_addr);
        iram_chk = 1'b1;
        dram_chk = 1'b1;
    end
    @(negedge clk);
    iram_chk = 1'b0;
    dram_chk = 1'b0;
    dram_rd_addr = '0;
endtask

// ############################################################
// test sequence
// ############################################################

initial begin
    logic [31:0] a;
    rng = 32'h49a6d9de;
    rst_n = 1'b0;
    host_req = 1'b0;
    host_op = loader_pkg::LOAD_OP_WRITE;
    host_addr = '0;
    host_wdata = '0;
    host_exp = '0;
    iram_rd_addr = '0;
    dram_rd_addr = '0;
    dram_wr_addr = '0;
    dram_wr_data = '0;
    dram_wr_byte_en = 4'h0;
    iram_exp = '0;
    dram_exp = '0;
    iram_chk = 1'b0;
    dram_chk = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // host fill of both windows, then byte readback.
    for (int r = 0; r < WIN_BYTES; r++) begin
        rng = xorshift(rng);
        host_access(loader_pkg::LOAD_OP_WRITE, win_addr(`MEM_IRAM_TAG, r, IRAM_BYTES),
                    rng[7:0], 1'b0);
        host_access(loader_pkg::LOAD_OP_WRITE, win_addr(`MEM_DRAM_TAG, r, DRAM_BYTES),
                    rng[15:8], 1'b0);
    end
    for (int r = 0; r < WIN_BYTES; r++) begin
        host_access(loader_pkg::LOAD_OP_READ, win_addr(`MEM_IRAM_TAG, r, IRAM_BYTES),
                    8'h00, 1'b0);
        host_access(loader_pkg::LOAD_OP_READ, win_addr(`MEM_DRAM_TAG, r, DRAM_BYTES),
                    8'h00, 1'b0);
    end

    // fetches at every byte offset.
    verify_window();

    // unaligned DRAM writes with random strobes.
    for (int i = 0; i < DWR_COUNT; i++) begin
        rng = xorshift(rng);
        a = win_addr(`MEM_DRAM_TAG, int'(rng % WIN_SPAN), DRAM_BYTES);
        core_write(a, xorshift(rng), rng[27:24]);
        rng = xorshift(rng);
    end
    core_idle();
    verify_window();

    // pipelined DRAM reads, one per cycle.
    for (int i = 0; i < DRD_COUNT; i++) begin
        @(negedge clk);
        rng = xorshift(rng);
        dram_rd_addr = win_addr(`MEM_DRAM_TAG, int'(rng % WIN_SPAN), DRAM_BYTES);
        dram_exp = ref_word(dram_rd_addr);
        dram_chk = 1'b1;
    end
    @(negedge clk);
    dram_chk = 1'b0;
    dram_rd_addr = '0;

    // accesses outside both regions.
    for (int i = 0; i < OOR_COUNT; i++) begin
        rng = xorshift(rng);
        a = win_addr(oor_tag(i), int'(rng % WIN_SPAN), DRAM_BYTES);
        core_write(a, xorshift(rng), 4'hf);
        core_write(win_addr(`MEM_IRAM_TAG, int'(rng % WIN_SPAN), IRAM_BYTES), ~rng, 4'hf);
    end
    core_idle();
    for (int i = 0; i < OOR_COUNT; i++) begin
        rng = xorshift(rng);
        a = win_addr(oor_tag(i), i, IRAM_BYTES);
        host_access(loader_pkg::LOAD_OP_WRITE, a, rng[7:0], 1'b0);
        host_access(loader_pkg::LOAD_OP_READ, a, 8'h00, 1'b0);
    end
    verify_window();

    // core writes racing a loader transaction.
    for (int i = 0; i < NOISE_COUNT; i++) begin
        rng = xorshift(rng);
        a = win_addr((i % 2) ? `MEM_IRAM_TAG : `MEM_DRAM_TAG, int'(rng % WIN_BYTES),
                     DRAM_BYTES);
        host_access(loader_pkg::LOAD_OP_WRITE, a, rng[15:8], 1'b1);
    end
    verify_window();

    repeat (2) @(negedge clk);
    $display("checks %0d, check errors %0d, handshake errors %0d", chk_cnt, err_cnt, hs_errs);
    if (err_cnt == 0 && hs_errs == 0 && chk_cnt > 0) begin
        $display("Done: no errors");
    end else begin
        $display("Done: errors found");
    end
    $finish;
end

initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with the tests still running", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
end

endmodule

`default_nettype wire

// File: mem_subsys.f
+incdir+rtl
rtl/mem_map_pkg.sv
rtl/loader_pkg.sv
rtl/bank_port_if.sv
rtl/byte_bank.sv
rtl/lane_router.sv
rtl/split_ram.sv
rtl/boot_loader.sv
rtl/mem_subsys_top.sv
tb/mem_checker.sv
tb/tb_mem_subsys.sv

// File: Makefile
SIM       ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_mem_subsys
FILELIST  ?= mem_subsys.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
